//--- tb.f
hdl/sonata_pkg.sv
hdl/periph_xbar.sv
hdl/gpio_regs.sv
hdl/pwm_bank.sv
hdl/mtimer.sv
hdl/rev_tag_ram.sv
hdl/periph_subsystem.sv
dv/periph_properties.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# Builds tb_top with Verilator from tb.f, runs it and scans sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f \
  -o Vtb_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

//--- dv/tb_top.sv
// Directed tests over the host port; inputs change on the falling edge
// Tag memory words are written before they are read, contents start undefined
`timescale 1ns/10ps

module tb_top;
  import sonata_pkg::*;

  localparam int unsigned GpiWidth     = 13;
  localparam int unsigned GpoWidth     = 24;
  localparam int unsigned PwmWidth     = 12;
  localparam int unsigned PwmCtrSize   = 8;
  localparam int unsigned RevTagDepth  = 4096;
  localparam int unsigned TagIdxBits   = $clog2(RevTagDepth);
  localparam int unsigned RspTimeout   = 8;   // Cycles to wait for rvalid
  localparam int unsigned PollLimit    = 8;   // GPIO input reads
  localparam int unsigned IrqTimeout   = 16;
  localparam bus_data_t   GpoMask      = bus_data_t'((64'd1 << GpoWidth) - 64'd1);

  logic                  clk_sys;
  logic                  rst_sys_n;
  bus_req_t              host_req;
  logic                  host_gnt;
  bus_rsp_t              host_rsp;
  logic [GpiWidth-1:0]   gp_in;
  logic [GpoWidth-1:0]   gp_out;
  logic [PwmWidth-1:0]   pwm_out;
  logic                  tsmap_cs;
  bus_addr_t             tsmap_addr;
  bus_data_t             tsmap_rdata;
  logic                  timer_irq;

  int unsigned           mismatch_cnt;
  int unsigned           timeout_cnt;
  bus_data_t             rng_q;
  bus_data_t             gpo_m;                 // Expected gp_o
  logic [7:0]            duty_m   [PwmWidth];
  logic [7:0]            period_m [PwmWidth];
  int unsigned           tag_idx  [8];
  bus_data_t             tag_m    [8];

  sonata_periph_subsystem #(
    .GpiWidth   (GpiWidth),
    .GpoWidth   (GpoWidth),
    .PwmWidth   (PwmWidth),
    .PwmCtrSize (PwmCtrSize),
    .RevTagDepth(RevTagDepth)
  ) u_dut (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .host_req_i   (host_req),
    .host_gnt_o   (host_gnt),
    .host_rsp_o   (host_rsp),
    .gp_i         (gp_in),
    .gp_o         (gp_out),
    .pwm_o        (pwm_out),
    .tsmap_cs_i   (tsmap_cs),
    .tsmap_addr_i (tsmap_addr),
    .tsmap_rdata_o(tsmap_rdata),
    .timer_irq_o  (timer_irq)
  );

  bind sonata_periph_subsystem periph_properties u_props (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .host_req_i(host_req_i),
    .host_gnt_i(host_gnt_o),
    .host_rsp_i(host_rsp_o)
  );

  always #4 clk_sys = ~clk_sys;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic bus_data_t xorshift32();
    bus_data_t x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  // Bytes with be set come from the new word
  function automatic bus_data_t merge_bytes(bus_data_t old_w, bus_data_t new_w, bus_be_t be);
    bus_data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic bus_addr_t dev_addr(int unsigned dev, int unsigned offset);
    return bus_addr_t'((dev << DevSelLsb) | offset);
  endfunction

  function automatic bus_req_t make_req(logic we, bus_be_t be, bus_addr_t addr,
                                        bus_data_t wdata);
    bus_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  task automatic check_data(string name, bus_data_t exp, bus_data_t act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_gpo(string name, logic [GpoWidth-1:0] exp, logic [GpoWidth-1:0] act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %06h actual %06h", name, exp, act);
    end
  endtask

  // Called on a falling edge, returns on the falling edge that shows rvalid
  task automatic bus_access(input bus_req_t req, output bus_rsp_t rsp);
    int unsigned waited;
    host_req = req;
    @(negedge clk_sys);
    check_bit("host_gnt", 1'b1, host_gnt);  // Every request is accepted
    host_req.req = 1'b0;
    waited = 0;
    while (!host_rsp.rvalid && waited < RspTimeout) begin
      @(negedge clk_sys);
      waited++;
    end
    if (!host_rsp.rvalid) begin
      timeout_cnt++;
      $display("Timeout: no response to the request at address %08h", req.addr);
    end
    rsp = host_rsp;
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_be_t be, input bus_data_t wdata,
                           output bus_rsp_t rsp);
    bus_access(make_req(1'b1, be, addr, wdata), rsp);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_rsp_t rsp);
    bus_access(make_req(1'b0, 4'hf, addr, '0), rsp);
  endtask

  // Counts high cycles of one channel after the counter has settled
  task automatic count_pwm_high(input int unsigned ch, input int unsigned settle,
                                input int unsigned window, output int unsigned highs);
    highs = 0;
    repeat (settle) @(negedge clk_sys);
    for (int unsigned c = 0; c < window; c++) begin
      if (pwm_out[ch]) highs++;
      @(negedge clk_sys);
    end
  endtask

  task automatic wait_irq(input logic level, input string name);
    int unsigned waited;
    waited = 0;
    while (timer_irq !== level && waited < IrqTimeout) begin
      @(negedge clk_sys);
      waited++;
    end
    if (timer_irq !== level) begin
      timeout_cnt++;
      $display("Timeout: timer interrupt never reached %b in %s", level, name);
    end
    check_bit(name, level, timer_irq);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_gpio();
    bus_rsp_t            rsp;
    bus_data_t           wdata;
    bus_be_t             be;
    logic [GpiWidth-1:0] gpi_val;
    int unsigned         polls;
    check_gpo("gpio_reset", '0, gp_out);
    for (int i = 0; i < 8; i++) begin
      wdata = xorshift32();
      be    = bus_be_t'(xorshift32());
      bus_write(dev_addr(GPIO, GpioOutOffset), be, wdata, rsp);
      check_data("gpio_write_rdata", '0, rsp.rdata);
      gpo_m = merge_bytes(gpo_m, wdata, be) & GpoMask;
      check_gpo("gpio_out_pins", gpo_m[GpoWidth-1:0], gp_out);
      bus_read(dev_addr(GPIO, GpioOutOffset), rsp);
      check_data("gpio_out_read", gpo_m, rsp.rdata);
    end
    gpi_val = GpiWidth'(xorshift32());
    gp_in   = gpi_val;
    polls   = 0;
    rsp     = '0;
    while (rsp.rdata !== bus_data_t'(gpi_val) && polls < PollLimit) begin
      bus_read(dev_addr(GPIO, GpioInOffset), rsp);
      polls++;
    end
    if (rsp.rdata !== bus_data_t'(gpi_val)) begin
      timeout_cnt++;
      $display("Timeout: GPIO input register never showed the driven gp_i value");
    end
    check_data("gpio_in_read", bus_data_t'(gpi_val), rsp.rdata);
  endtask

  task automatic test_pwm();
    bus_rsp_t    rsp;
    bus_data_t   r;
    int unsigned ch;
    int unsigned highs;
    int unsigned exp_highs;
    check_data("pwm_reset", '0, bus_data_t'(pwm_out));
    for (int i = 0; i < 5; i++) begin
      ch = (i < 4) ? (i * 5 + 1) % PwmWidth : 2;
      r  = xorshift32();
      duty_m[ch]   = (i < 4) ? r[7:0] : 8'd0;    // Last channel checks duty 0
      period_m[ch] = (i < 4) ? r[15:8] : 8'd20;
      bus_write(dev_addr(PWM, ch * 4), 4'b0011, {16'b0, period_m[ch], duty_m[ch]}, rsp);
      bus_read(dev_addr(PWM, ch * 4), rsp);
      check_data("pwm_regs_read", {16'b0, period_m[ch], duty_m[ch]}, rsp.rdata);
      // High for min(duty, period+1) cycles per period+1 window
      exp_highs = (duty_m[ch] < period_m[ch] + 1) ? duty_m[ch] : period_m[ch] + 1;
      count_pwm_high(ch, period_m[ch] + 3, period_m[ch] + 1, highs);
      check_data("pwm_high_cycles", bus_data_t'(exp_highs), bus_data_t'(highs));
    end
    count_pwm_high(2, 0, 2 * (period_m[2] + 1), highs);
    check_data("pwm_duty_zero", '0, bus_data_t'(highs));
  endtask

  task automatic test_timer();
    bus_rsp_t  rsp;
    bus_data_t t1;
    bus_read(dev_addr(TIMER, TimerCmpHighOffset), rsp);
    check_data("timer_cmp_reset", '1, rsp.rdata);
    bus_write(dev_addr(TIMER, TimerCtrlOffset), 4'b0001, 32'h1, rsp);
    bus_read(dev_addr(TIMER, TimerLowOffset), rsp);
    t1 = rsp.rdata;
    repeat (3) @(negedge clk_sys);
    bus_read(dev_addr(TIMER, TimerLowOffset), rsp);
    check_bit("timer_counts_up", 1'b1, rsp.rdata > t1);
    check_bit("timer_irq_idle", 1'b0, timer_irq);
    bus_write(dev_addr(TIMER, TimerCmpLowOffset), 4'hf, '0, rsp);
    bus_write(dev_addr(TIMER, TimerCmpHighOffset), 4'hf, '0, rsp);
    wait_irq(1'b1, "timer_irq_set");
    bus_write(dev_addr(TIMER, TimerCmpLowOffset), 4'hf, '1, rsp);
    bus_write(dev_addr(TIMER, TimerCmpHighOffset), 4'hf, '1, rsp);
    wait_irq(1'b0, "timer_irq_clear");
  endtask

  task automatic test_tags();
    bus_rsp_t  rsp;
    bus_data_t init;
    bus_data_t wdata;
    bus_be_t   be;
    bus_addr_t noise;
    for (int i = 0; i < 8; i++) begin
      tag_idx[i] = (xorshift32() % (RevTagDepth / 8)) * 8 + i;  // Distinct by low bits
      init  = xorshift32();
      wdata = xorshift32();
      be    = bus_be_t'(xorshift32());
      bus_write(dev_addr(REV_TAGS, tag_idx[i] * 4), 4'hf, init, rsp);
      bus_write(dev_addr(REV_TAGS, tag_idx[i] * 4), be, wdata, rsp);
      tag_m[i] = merge_bytes(init, wdata, be);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(dev_addr(REV_TAGS, tag_idx[i] * 4), rsp);
      check_data("tag_bus_read", tag_m[i], rsp.rdata);
    end
    for (int i = 0; i < 8; i++) begin
      noise      = xorshift32();
      tsmap_cs   = 1'b1;
      // Bits above the word index must be ignored
      tsmap_addr = (noise << (TagIdxBits + 2)) | (bus_addr_t'(tag_idx[i]) << 2);
      @(negedge clk_sys);
      tsmap_cs = 1'b0;
      check_data("tag_tsmap_read", tag_m[i], tsmap_rdata);
      // Address moves to another word while cs is low
      tsmap_addr = bus_addr_t'(tag_idx[(i + 1) % 8]) << 2;
      @(negedge clk_sys);
      check_data("tag_tsmap_hold", tag_m[i], tsmap_rdata);
    end
  endtask

  task automatic test_unmapped();
    bus_rsp_t rsp;
    bus_read(dev_addr(5, 0), rsp);
    check_bit("unmapped_read_err", 1'b1, rsp.err);
    check_data("unmapped_read_data", '0, rsp.rdata);
    bus_write(dev_addr(15, 'h40), 4'hf, xorshift32(), rsp);
    check_bit("unmapped_write_err", 1'b1, rsp.err);
    bus_read(dev_addr(GPIO, GpioOutOffset), rsp);
    check_bit("mapped_read_err", 1'b0, rsp.err);
  endtask

  task automatic test_back_to_back();
    bus_req_t  reqs[$];
    bus_data_t exp_data[$];
    logic      exp_err[$];
    bus_data_t v;
    bus_data_t w;
    v = xorshift32();
    w = xorshift32();
    gpo_m = v & GpoMask;
    reqs.push_back(make_req(1'b1, 4'hf, dev_addr(GPIO, GpioOutOffset), v));
    exp_data.push_back('0);
    exp_err.push_back(1'b0);
    reqs.push_back(make_req(1'b0, 4'hf, dev_addr(GPIO, GpioOutOffset), '0));
    exp_data.push_back(gpo_m);
    exp_err.push_back(1'b0);
    reqs.push_back(make_req(1'b0, 4'hf, dev_addr(REV_TAGS, tag_idx[3] * 4), '0));
    exp_data.push_back(tag_m[3]);
    exp_err.push_back(1'b0);
    reqs.push_back(make_req(1'b0, 4'hf, dev_addr(PWM, 4), '0));
    exp_data.push_back({16'b0, period_m[1], duty_m[1]});
    exp_err.push_back(1'b0);
    reqs.push_back(make_req(1'b0, 4'hf, dev_addr(7, 0), '0));
    exp_data.push_back('0);
    exp_err.push_back(1'b1);
    reqs.push_back(make_req(1'b1, 4'hf, dev_addr(REV_TAGS, tag_idx[0] * 4), w));
    exp_data.push_back('0);
    exp_err.push_back(1'b0);
    reqs.push_back(make_req(1'b0, 4'hf, dev_addr(REV_TAGS, tag_idx[0] * 4), '0));
    exp_data.push_back(w);
    exp_err.push_back(1'b0);
    tag_m[0] = w;
    // One request per cycle, response k-1 visible while request k is driven
    for (int k = 0; k <= reqs.size(); k++) begin
      if (k > 0) begin
        check_bit("b2b_rvalid", 1'b1, host_rsp.rvalid);
        check_data("b2b_rdata", exp_data[k-1], host_rsp.rdata);
        check_bit("b2b_err", exp_err[k-1], host_rsp.err);
      end
      host_req = (k < reqs.size()) ? reqs[k] : '0;
      @(negedge clk_sys);
    end
    check_bit("b2b_idle", 1'b0, host_rsp.rvalid);
  endtask

  //////////////////////////////
  // Sequence
  //////////////////////////////

  initial begin
    clk_sys      = 1'b0;
    rst_sys_n    = 1'b0;
    host_req     = '0;
    gp_in        = '0;
    tsmap_cs     = 1'b0;
    tsmap_addr   = '0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    rng_q        = 32'hc9cb;
    gpo_m        = '0;
    for (int i = 0; i < PwmWidth; i++) begin
      duty_m[i]   = '0;
      period_m[i] = '0;
    end
    repeat (3) @(negedge clk_sys);
    rst_sys_n = 1'b1;
    @(negedge clk_sys);
    check_bit("irq_reset", 1'b0, timer_irq);

    test_gpio();
    test_pwm();
    test_timer();
    test_tags();
    test_unmapped();
    test_back_to_back();

    $display("Error counts: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- dv/periph_properties.sv
// Host port rules sampled on the rising clock edge
// Checks are idle while reset is held
`timescale 1ns/10ps

module periph_properties (
  input logic                 clk_sys_i,
  input logic                 rst_sys_ni,
  input sonata_pkg::bus_req_t host_req_i,
  input logic                 host_gnt_i,
  input sonata_pkg::bus_rsp_t host_rsp_i
);

  // Grant is a plain copy of the request
  gnt_follows_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_gnt_i == host_req_i.req)
    else $error("host grant differs from host request");

  rvalid_after_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_req_i.req |=> host_rsp_i.rvalid)
    else $error("no response one cycle after a request");

  no_spurious_rvalid: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    !host_req_i.req |=> !host_rsp_i.rvalid)
    else $error("response valid without a request in the cycle before");

  err_needs_rvalid: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rsp_i.err |-> host_rsp_i.rvalid)
    else $error("error flag raised outside a response");

endmodule

//--- hdl/periph_subsystem.sv
// One host port to GPIO, PWM, timer and tag memory; 1-cycle responses
// The tsmap port bypasses the crossbar and reads the tag memory directly
`timescale 1ns/10ps

module sonata_periph_subsystem #(
  parameter int unsigned GpiWidth    = 13,
  parameter int unsigned GpoWidth    = 24,
  parameter int unsigned PwmWidth    = 12,
  parameter int unsigned PwmCtrSize  = 8,
  parameter int unsigned RevTagDepth = 4096  // 16 KiB of tags
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,

  // Host port
  input  sonata_pkg::bus_req_t  host_req_i,
  output logic                  host_gnt_o,
  output sonata_pkg::bus_rsp_t  host_rsp_o,

  input  logic [GpiWidth-1:0]   gp_i,
  output logic [GpoWidth-1:0]   gp_o,
  output logic [PwmWidth-1:0]   pwm_o,

  // Temporal safety lookup
  input  logic                  tsmap_cs_i,
  input  sonata_pkg::bus_addr_t tsmap_addr_i,
  output sonata_pkg::bus_data_t tsmap_rdata_o,

  output logic                  timer_irq_o
);
  import sonata_pkg::*;

  dev_req_t  [NrDevices-1:0] dev_req;
  bus_data_t [NrDevices-1:0] dev_rdata;

  periph_xbar u_xbar (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .host_req_i (host_req_i),
    .host_gnt_o (host_gnt_o),
    .host_rsp_o (host_rsp_o),
    .dev_req_o  (dev_req),
    .dev_rdata_i(dev_rdata)
  );

  gpio_regs #(
    .GpiWidth(GpiWidth),
    .GpoWidth(GpoWidth)
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .dev_req_i (dev_req[GPIO]),
    .rdata_o   (dev_rdata[GPIO]),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  pwm_bank #(
    .PwmWidth  (PwmWidth),
    .PwmCtrSize(PwmCtrSize)
  ) u_pwm (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .dev_req_i (dev_req[PWM]),
    .rdata_o   (dev_rdata[PWM]),
    .pwm_o     (pwm_o)
  );

  mtimer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .dev_req_i  (dev_req[TIMER]),
    .rdata_o    (dev_rdata[TIMER]),
    .timer_irq_o(timer_irq_o)
  );

  rev_tag_ram #(
    .RevTagDepth(RevTagDepth)
  ) u_rev_tags (
    .clk_sys_i    (clk_sys_i),
    .dev_req_i    (dev_req[REV_TAGS]),
    .rdata_o      (dev_rdata[REV_TAGS]),
    .tsmap_cs_i   (tsmap_cs_i),
    .tsmap_addr_i (tsmap_addr_i),
    .tsmap_rdata_o(tsmap_rdata_o)
  );

endmodule

//--- hdl/rev_tag_ram.sv
// Contents are undefined after reset; word index wraps at RevTagDepth
// Same-cycle write and tsmap read of one word returns the old value
`timescale 1ns/10ps

module rev_tag_ram #(
  parameter int unsigned RevTagDepth = 4096
) (
  input  logic                  clk_sys_i,
  input  sonata_pkg::dev_req_t  dev_req_i,
  output sonata_pkg::bus_data_t rdata_o,
  input  logic                  tsmap_cs_i,
  input  sonata_pkg::bus_addr_t tsmap_addr_i,
  output sonata_pkg::bus_data_t tsmap_rdata_o
);
  import sonata_pkg::*;

  localparam int unsigned AddrW = $clog2(RevTagDepth);

  logic [AddrW-1:0] a_idx;
  logic [AddrW-1:0] b_idx;
  bus_data_t        mem [RevTagDepth];

  // Word index from bit 2 up on both ports
  assign a_idx = dev_req_i.offset[2 +: AddrW];
  assign b_idx = tsmap_addr_i[2 +: AddrW];

  // Port A, bus side
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req) begin
      if (dev_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (dev_req_i.be[b]) begin
            mem[a_idx][b*8 +: 8] <= dev_req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[a_idx];
      end
    end
  end

  // Port B, read only for the tsmap lookup
  always_ff @(posedge clk_sys_i) begin
    if (tsmap_cs_i) begin
      tsmap_rdata_o <= mem[b_idx];
    end
  end

endmodule

//--- hdl/mtimer.sv
// Halves are written separately, so a 64-bit update is not atomic
// The interrupt level lags the compare by one cycle
`timescale 1ns/10ps

module mtimer (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  sonata_pkg::dev_req_t  dev_req_i,
  output sonata_pkg::bus_data_t rdata_o,
  output logic                  timer_irq_o
);
  import sonata_pkg::*;

  reg_addr_t reg_addr;
  logic      wr;
  logic      en_q;
  logic      en_d;
  mtime_t    mtime_q;
  mtime_t    mtime_d;
  mtime_t    mtimecmp_q;
  mtime_t    mtimecmp_d;
  logic      irq_q;
  bus_data_t rdata_d;

  assign reg_addr = dev_req_i.offset[7:0];
  assign wr       = dev_req_i.req & dev_req_i.we;

  ///////////////////////////////
  // Register updates
  ///////////////////////////////

  always_comb begin
    en_d       = en_q;
    mtime_d    = en_q ? mtime_q + 64'd1 : mtime_q;
    mtimecmp_d = mtimecmp_q;

    if (wr) begin
      unique case (reg_addr)
        TimerCtrlOffset: begin
          if (dev_req_i.be[0]) begin
            en_d = dev_req_i.wdata[0];
          end
        end
        // A bus write overrides the increment of that half
        TimerLowOffset:
          mtime_d[31:0] = be_merge(mtime_q[31:0], dev_req_i.wdata, dev_req_i.be);
        TimerHighOffset:
          mtime_d[63:32] = be_merge(mtime_q[63:32], dev_req_i.wdata, dev_req_i.be);
        TimerCmpLowOffset:
          mtimecmp_d[31:0] = be_merge(mtimecmp_q[31:0], dev_req_i.wdata, dev_req_i.be);
        TimerCmpHighOffset:
          mtimecmp_d[63:32] = be_merge(mtimecmp_q[63:32], dev_req_i.wdata, dev_req_i.be);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      en_q       <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // Far future, no interrupt
      irq_q      <= 1'b0;
    end else begin
      en_q       <= en_d;
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
    end
  end

  ///////////////////////////////
  // Read back
  ///////////////////////////////

  always_comb begin
    unique case (reg_addr)
      TimerCtrlOffset:    rdata_d = {31'b0, en_q};
      TimerLowOffset:     rdata_d = mtime_q[31:0];
      TimerHighOffset:    rdata_d = mtime_q[63:32];
      TimerCmpLowOffset:  rdata_d = mtimecmp_q[31:0];
      TimerCmpHighOffset: rdata_d = mtimecmp_q[63:32];
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req && !dev_req_i.we) begin
      rdata_o <= rdata_d;
    end
  end

  assign timer_irq_o = irq_q;

endmodule

//--- hdl/pwm_bank.sv
// PwmCtrSize up to 8; be[0] writes duty, be[1] writes period
// Output is registered, so it trails the counter by one cycle
`timescale 1ns/10ps

module pwm_bank #(
  parameter int unsigned PwmWidth   = 12,
  parameter int unsigned PwmCtrSize = 8
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  sonata_pkg::dev_req_t  dev_req_i,
  output sonata_pkg::bus_data_t rdata_o,
  output logic [PwmWidth-1:0]   pwm_o
);
  import sonata_pkg::*;

  localparam int unsigned ChanW = $clog2(PwmWidth);

  reg_addr_t             reg_addr;
  logic [5:0]            chan;
  logic [ChanW-1:0]      chan_idx;
  logic                  chan_ok;
  logic                  wr;
  bus_data_t             rdata_d;
  logic [PwmCtrSize-1:0] duty_q   [PwmWidth];
  logic [PwmCtrSize-1:0] period_q [PwmWidth];
  logic [PwmCtrSize-1:0] ctr_q    [PwmWidth];
  logic [PwmWidth-1:0]   pwm_q;

  assign reg_addr = dev_req_i.offset[7:0];
  assign chan     = reg_addr[7:2];      // One word per channel
  assign chan_idx = chan[ChanW-1:0];
  assign chan_ok  = (chan < PwmWidth);
  assign wr       = dev_req_i.req & dev_req_i.we;

  ///////////////////////////////
  // Channels
  ///////////////////////////////

  for (genvar i = 0; i < PwmWidth; i++) begin : gen_chan
    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        duty_q[i]   <= '0;
        period_q[i] <= '0;
        ctr_q[i]    <= '0;
        pwm_q[i]    <= 1'b0;
      end else begin
        if (wr && chan == 6'(i)) begin
          if (dev_req_i.be[0]) begin
            duty_q[i] <= dev_req_i.wdata[PwmCtrSize-1:0];
          end
          if (dev_req_i.be[1]) begin
            period_q[i] <= dev_req_i.wdata[PwmPeriodLsb +: PwmCtrSize];
          end
        end
        // Wrap at period, also catches a period lowered below the count
        if (ctr_q[i] >= period_q[i]) begin
          ctr_q[i] <= '0;
        end else begin
          ctr_q[i] <= ctr_q[i] + 1'b1;
        end
        pwm_q[i] <= (ctr_q[i] < duty_q[i]);
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    if (chan_ok) begin
      rdata_d[PwmCtrSize-1:0]               = duty_q[chan_idx];
      rdata_d[PwmPeriodLsb +: PwmCtrSize] = period_q[chan_idx];
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req && !dev_req_i.we) begin
      rdata_o <= rdata_d;
    end
  end

  assign pwm_o = pwm_q;

endmodule

//--- hdl/gpio_regs.sv
// GpoWidth must not exceed 32; gp_i is sampled through two flops
`timescale 1ns/10ps

module gpio_regs #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  sonata_pkg::dev_req_t  dev_req_i,
  output sonata_pkg::bus_data_t rdata_o,
  input  logic [GpiWidth-1:0]   gp_i,
  output logic [GpoWidth-1:0]   gp_o
);
  import sonata_pkg::*;

  reg_addr_t           reg_addr;
  logic                out_wr;
  bus_data_t           gpo_merged;
  bus_data_t           rdata_d;
  logic [GpoWidth-1:0] gpo_q;
  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_q;

  assign reg_addr   = dev_req_i.offset[7:0];
  assign out_wr     = dev_req_i.req & dev_req_i.we & (reg_addr == GpioOutOffset);
  assign gpo_merged = be_merge(bus_data_t'(gpo_q), dev_req_i.wdata, dev_req_i.be);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_q      <= '0;
    end else begin
      gpi_meta_q <= gp_i;        // First sync stage
      gpi_q      <= gpi_meta_q;  // Input register
      if (out_wr) begin
        gpo_q <= gpo_merged[GpoWidth-1:0];
      end
    end
  end

  always_comb begin
    unique case (reg_addr)
      GpioOutOffset: rdata_d = bus_data_t'(gpo_q);
      GpioInOffset:  rdata_d = bus_data_t'(gpi_q);
      default:       rdata_d = '0;
    endcase
  end

  // Read data held until the next read
  always_ff @(posedge clk_sys_i) begin
    if (dev_req_i.req && !dev_req_i.we) begin
      rdata_o <= rdata_d;
    end
  end

  assign gp_o = gpo_q;

endmodule

//--- hdl/periph_xbar.sv
// Single host, fixed one-cycle response, no back-pressure
// Unmapped selects answer with err and zero data
`timescale 1ns/10ps

module periph_xbar (
  input  logic                                            clk_sys_i,
  input  logic                                            rst_sys_ni,
  input  sonata_pkg::bus_req_t                            host_req_i,
  output logic                                            host_gnt_o,
  output sonata_pkg::bus_rsp_t                            host_rsp_o,
  output sonata_pkg::dev_req_t  [sonata_pkg::NrDevices-1:0] dev_req_o,
  input  sonata_pkg::bus_data_t [sonata_pkg::NrDevices-1:0] dev_rdata_i
);
  import sonata_pkg::*;

  bus_device_e dev_sel;
  bus_device_e sel_q;
  logic        rvalid_q;
  logic        we_q;
  bus_data_t   rdata_mux;

  assign host_gnt_o = host_req_i.req;  // Every request is accepted

  ///////////////////////////////
  // Request side
  ///////////////////////////////

  always_comb begin
    unique case (host_req_i.addr[DevSelMsb:DevSelLsb])
      4'd0:    dev_sel = GPIO;
      4'd1:    dev_sel = PWM;
      4'd2:    dev_sel = TIMER;
      4'd3:    dev_sel = REV_TAGS;
      default: dev_sel = NONE;
    endcase
  end

  // Payload is broadcast, only req is steered
  for (genvar i = 0; i < NrDevices; i++) begin : gen_dev_req
    assign dev_req_o[i] = '{
      req:    host_req_i.req & (dev_sel == bus_device_e'(i)),
      we:     host_req_i.we,
      be:     host_req_i.be,
      offset: host_req_i.addr[15:0],
      wdata:  host_req_i.wdata
    };
  end

  ///////////////////////////////
  // Response side
  ///////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      sel_q    <= NONE;
    end else begin
      rvalid_q <= host_req_i.req;
      if (host_req_i.req) begin
        we_q  <= host_req_i.we;
        sel_q <= dev_sel;
      end
    end
  end

  always_comb begin
    unique case (sel_q)
      GPIO:     rdata_mux = dev_rdata_i[GPIO];
      PWM:      rdata_mux = dev_rdata_i[PWM];
      TIMER:    rdata_mux = dev_rdata_i[TIMER];
      REV_TAGS: rdata_mux = dev_rdata_i[REV_TAGS];
      default:  rdata_mux = '0;
    endcase
  end

  // Writes and errors return zero data
  assign host_rsp_o.rvalid = rvalid_q;
  assign host_rsp_o.err    = rvalid_q & (sel_q == NONE);
  assign host_rsp_o.rdata  = (rvalid_q && !we_q) ? rdata_mux : '0;

endmodule

//--- hdl/sonata_pkg.sv
// Shared bus types and address map for the peripheral subsystem
// Devices sit on a 64 KiB stride selected by address bits 19:16
package sonata_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_be_t;
  typedef logic [7:0]  reg_addr_t;    // Register offset inside a device
  typedef logic [15:0] dev_offset_t;  // Full offset field handed to a device
  typedef logic [63:0] mtime_t;

  typedef struct packed {
    logic      req;
    logic      we;
    bus_be_t   be;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic      rvalid;
    bus_data_t rdata;
    logic      err;
  } bus_rsp_t;

  typedef struct packed {
    logic        req;
    logic        we;
    bus_be_t     be;
    dev_offset_t offset;
    bus_data_t   wdata;
  } dev_req_t;

  typedef enum logic [2:0] {
    GPIO,
    PWM,
    TIMER,
    REV_TAGS,
    NONE
  } bus_device_e;

  localparam int unsigned NrDevices = 4;

  ///////////////////////////////
  // Address map
  ///////////////////////////////

  localparam int unsigned DevSelLsb = 16;
  localparam int unsigned DevSelMsb = 19;

  localparam reg_addr_t GpioOutOffset      = 8'h00;
  localparam reg_addr_t GpioInOffset       = 8'h04;

  localparam reg_addr_t TimerCtrlOffset    = 8'h00;  // Bit 0 is enable
  localparam reg_addr_t TimerLowOffset     = 8'h04;
  localparam reg_addr_t TimerHighOffset    = 8'h08;
  localparam reg_addr_t TimerCmpLowOffset  = 8'h0C;
  localparam reg_addr_t TimerCmpHighOffset = 8'h10;

  // PWM channel n sits at 4*n, duty from bit 0
  localparam int unsigned PwmPeriodLsb = 8;

  // Byte-wise merge of a write into an existing word
  function automatic bus_data_t be_merge(bus_data_t old_q, bus_data_t new_d, bus_be_t be);
    bus_data_t merged;
    for (int b = 0; b < 4; b++) begin
      merged[b*8 +: 8] = be[b] ? new_d[b*8 +: 8] : old_q[b*8 +: 8];
    end
    return merged;
  endfunction

endpackage
